/* source/reg_access_pkg.sv */
// Host-side register port types.
// One strobe per request, at most one of ren and wen high in a cycle.
// Read data is only meaningful while rack is high.
`default_nettype none

package reg_access_pkg;

    localparam int REG_AW = 7;
    localparam int REG_DW = 8;

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [REG_DW-1:0] reg_data_t;

    // host request, sampled in the strobe cycle
    typedef struct packed {
        logic      ren;
        logic      wen;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    // response, one cycle after the request
    typedef struct packed {
        logic      wack;
        logic      rack;
        reg_data_t rdata;
    } reg_rsp_t;

    // chip access state, several enables may be high at once
    typedef struct packed {
        logic test;
        logic cfg;
        logic spi_ctrl;
    } access_state_t;

    typedef struct packed {
        logic wr_test;
        logic wr_cfg;
        logic wr_spi;
        logic rd_test;
        logic rd_cfg;
        logic rd_spi;
    } access_perm_t;

endpackage

`default_nettype wire

/* source/reg_map_pkg.sv */
// Register map of the control bank.
// Unlisted addresses are unmapped, reads return zero and writes are dropped.
// Permission table order must follow reg_id_e.
`default_nettype none

package reg_map_pkg;

    import reg_access_pkg::*;

    localparam int NUM_REGS = 8;

    typedef enum logic [$clog2(NUM_REGS)-1:0] {
        DEVICE_ID,
        MODE,
        COM_CONFIG1,
        COM_CONFIG2,
        STATUS1,
        MASK1,
        STATUS2,
        MASK2
    } reg_id_e;

    typedef logic [NUM_REGS-1:0] reg_sel_t;

    //============================================================
    // addresses
    //============================================================
    localparam reg_addr_t ADDR_DEVICE_ID   = 7'h00;
    localparam reg_addr_t ADDR_MODE        = 7'h01;
    localparam reg_addr_t ADDR_COM_CONFIG1 = 7'h02;
    localparam reg_addr_t ADDR_COM_CONFIG2 = 7'h03;
    localparam reg_addr_t ADDR_STATUS1     = 7'h08;
    localparam reg_addr_t ADDR_MASK1       = 7'h09;
    localparam reg_addr_t ADDR_STATUS2     = 7'h0A;
    localparam reg_addr_t ADDR_MASK2       = 7'h0B;

    //============================================================
    // reset values
    //============================================================
    localparam reg_data_t MODE_DEFAULT        = 8'h08;
    localparam reg_data_t COM_CONFIG1_DEFAULT = 8'h2B;
    localparam reg_data_t COM_CONFIG2_DEFAULT = 8'hFF;
    localparam reg_data_t MASK_DEFAULT        = 8'h00;
    localparam reg_data_t STATUS_DEFAULT      = 8'h00;

    // identifier, hv die in the high nibble
    localparam logic [3:0] HV_DEVICE_ID  = 4'h5;
    localparam logic [3:0] LV_DEVICE_ID  = 4'hA;
    localparam reg_data_t  DEVICE_ID_VAL = {HV_DEVICE_ID, LV_DEVICE_ID};

    //============================================================
    // access permissions
    //============================================================
    // no register is readable in cfg state
    localparam access_perm_t PERM_MODE = '{wr_test: 1'b1, wr_cfg: 1'b1, wr_spi: 1'b1,
                                           rd_test: 1'b1, rd_cfg: 1'b0, rd_spi: 1'b1};
    localparam access_perm_t PERM_CONFIG = '{wr_test: 1'b1, wr_cfg: 1'b1, wr_spi: 1'b0,
                                             rd_test: 1'b1, rd_cfg: 1'b0, rd_spi: 1'b1};
    localparam access_perm_t PERM_STATUS = '{wr_test: 1'b0, wr_cfg: 1'b1, wr_spi: 1'b1,
                                             rd_test: 1'b1, rd_cfg: 1'b0, rd_spi: 1'b1};
    localparam access_perm_t PERM_ID = '{wr_test: 1'b0, wr_cfg: 1'b0, wr_spi: 1'b0,
                                         rd_test: 1'b1, rd_cfg: 1'b0, rd_spi: 1'b1};

    localparam access_perm_t REG_PERM [NUM_REGS] = '{
        PERM_ID, PERM_MODE, PERM_CONFIG, PERM_CONFIG,
        PERM_STATUS, PERM_CONFIG, PERM_STATUS, PERM_CONFIG
    };

    // mode register fields, srst requests a soft reset
    typedef struct packed {
        logic [6:0] mode_sel;
        logic       srst;
    } mode_reg_t;

    localparam int SRST_HOLD_CYCLES = 2;
    localparam int SRST_CNT_W       = $clog2(SRST_HOLD_CYCLES + 1);

endpackage

`default_nettype wire

/* source/rstn_merge.sv */
// Merged bank reset, asserted asynchronously by i_arst_n.
// Released two clock edges after i_arst_n goes high.
// A soft request pulls the output low for SRST_HOLD_CYCLES cycles.
`timescale 1ns/1ps
`default_nettype none

module rstn_merge (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_srst,
    output logic o_rst_n
);

    import reg_map_pkg::*;

    logic                  sync_meta;
    logic                  rst_q;
    logic [SRST_CNT_W-1:0] hold_cnt;

    // remaining low cycles after the request edge
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hold_cnt <= '0;
        end else if (i_srst) begin
            hold_cnt <= SRST_CNT_W'(SRST_HOLD_CYCLES - 1);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // second sync stage also carries the soft hold
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_meta <= 1'b0;
            rst_q     <= 1'b0;
        end else begin
            sync_meta <= 1'b1;
            rst_q     <= sync_meta & ~i_srst & (hold_cnt == '0);
        end
    end

    assign o_rst_n = rst_q;

endmodule

`default_nettype wire

/* source/reg_access_decode.sv */
// Address decode and permission check, purely combinational.
// A select is raised only for a mapped address with the strobe present
// and at least one enabled access state allowing the operation.
`timescale 1ns/1ps
`default_nettype none

module reg_access_decode (
    input  reg_access_pkg::reg_req_t      i_req,
    input  reg_access_pkg::access_state_t i_access,
    output reg_map_pkg::reg_sel_t         o_rd_sel,
    output reg_map_pkg::reg_sel_t         o_wr_sel
);

    import reg_access_pkg::*;
    import reg_map_pkg::*;

    logic         hit;
    reg_id_e      id;
    access_perm_t perm;
    logic         rd_ok;
    logic         wr_ok;

    always_comb begin
        hit = 1'b1;
        id  = DEVICE_ID;
        case (i_req.addr)
            ADDR_DEVICE_ID:   id = DEVICE_ID;
            ADDR_MODE:        id = MODE;
            ADDR_COM_CONFIG1: id = COM_CONFIG1;
            ADDR_COM_CONFIG2: id = COM_CONFIG2;
            ADDR_STATUS1:     id = STATUS1;
            ADDR_MASK1:       id = MASK1;
            ADDR_STATUS2:     id = STATUS2;
            ADDR_MASK2:       id = MASK2;
            default:          hit = 1'b0;
        endcase
    end

    assign perm = REG_PERM[id];

    // any enabled state that grants the access is enough
    assign rd_ok = (i_access.test     & perm.rd_test) |
                   (i_access.cfg      & perm.rd_cfg)  |
                   (i_access.spi_ctrl & perm.rd_spi);
    assign wr_ok = (i_access.test     & perm.wr_test) |
                   (i_access.cfg      & perm.wr_cfg)  |
                   (i_access.spi_ctrl & perm.wr_spi);

    always_comb begin
        o_rd_sel = '0;
        o_wr_sel = '0;
        if (hit) begin
            o_rd_sel[id] = i_req.ren & rd_ok;
            o_wr_sel[id] = i_req.wen & wr_ok;
        end
    end

endmodule

`default_nettype wire

/* source/rw_reg.sv */
// Read/write register, loads on a write select.
// Read output is zero unless read-selected, so outputs can be ORed.
`timescale 1ns/1ps
`default_nettype none

module rw_reg #(
    parameter reg_access_pkg::reg_data_t DEFAULT_VAL = '0
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_wr_sel,
    input  logic                      i_rd_sel,
    input  reg_access_pkg::reg_data_t i_wdata,
    output reg_access_pkg::reg_data_t o_reg_data,
    output reg_access_pkg::reg_data_t o_rdata
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_data <= DEFAULT_VAL;
        end else if (i_wr_sel) begin
            o_reg_data <= i_wdata;
        end
    end

    assign o_rdata = i_rd_sel ? o_reg_data : '0;

endmodule

`default_nettype wire

/* source/rwc_reg.sv */
// Status register, bits set by event pulses, cleared by writing 1.
// An event and a clear of the same bit on one edge leave the bit set.
`timescale 1ns/1ps
`default_nettype none

module rwc_reg (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_wr_sel,
    input  logic                      i_rd_sel,
    input  reg_access_pkg::reg_data_t i_wdata,
    input  reg_access_pkg::reg_data_t i_event,
    output reg_access_pkg::reg_data_t o_reg_data,
    output reg_access_pkg::reg_data_t o_rdata
);

    import reg_map_pkg::*;

    // clear first, then OR in the events
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_data <= STATUS_DEFAULT;
        end else begin
            o_reg_data <= (o_reg_data & ~(i_wr_sel ? i_wdata : '0)) | i_event;
        end
    end

    assign o_rdata = i_rd_sel ? o_reg_data : '0;

endmodule

`default_nettype wire

/* source/reg_read_return.sv */
// Response path, one cycle of latency for every request.
// Every strobe is acknowledged, refused or unmapped reads return zero.
`timescale 1ns/1ps
`default_nettype none

module reg_read_return (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  reg_access_pkg::reg_req_t  i_req,
    input  logic                      i_id_sel,
    input  reg_access_pkg::reg_data_t i_rdata_vec [1:reg_map_pkg::NUM_REGS-1],
    output reg_access_pkg::reg_rsp_t  o_rsp
);

    import reg_access_pkg::*;
    import reg_map_pkg::*;

    reg_data_t rdata_or;
    reg_data_t rdata_q;
    logic      rack_q;
    logic      wack_q;

    // identifier has no storage, it enters here as a constant
    always_comb begin
        rdata_or = i_id_sel ? DEVICE_ID_VAL : '0;
        for (int i = 1; i < NUM_REGS; i++) begin
            rdata_or = rdata_or | i_rdata_vec[i];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rack_q <= 1'b0;
            wack_q <= 1'b0;
        end else begin
            rack_q <= i_req.ren;
            wack_q <= i_req.wen;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req.ren) begin
            rdata_q <= rdata_or;
        end
    end

    assign o_rsp = '{wack: wack_q, rack: rack_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* source/com_reg_bank.sv */
// Control register bank behind the SPI register port.
// Registers run on the merged reset, the response path on i_arst_n only,
// so requests issued around a soft reset are still acknowledged.
// Writes landing during the soft reset hold are lost.
`timescale 1ns/1ps
`default_nettype none

module com_reg_bank (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  reg_access_pkg::reg_req_t      i_req,
    input  reg_access_pkg::access_state_t i_access,
    input  reg_access_pkg::reg_data_t     i_int_status1,
    input  reg_access_pkg::reg_data_t     i_int_status2,
    output reg_access_pkg::reg_rsp_t      o_rsp,
    output reg_map_pkg::mode_reg_t        o_reg_mode,
    output reg_access_pkg::reg_data_t     o_reg_com_config1,
    output reg_access_pkg::reg_data_t     o_reg_com_config2,
    output reg_access_pkg::reg_data_t     o_reg_status1,
    output reg_access_pkg::reg_data_t     o_reg_mask1,
    output reg_access_pkg::reg_data_t     o_reg_status2,
    output reg_access_pkg::reg_data_t     o_reg_mask2,
    output logic                          o_rst_n
);

    import reg_access_pkg::*;
    import reg_map_pkg::*;

    reg_sel_t  rd_sel;
    reg_sel_t  wr_sel;
    reg_data_t rdata_vec [1:NUM_REGS-1];

    //============================================================
    // reset and access control
    //============================================================
    rstn_merge u_rstn_merge (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_srst   (o_reg_mode.srst),
        .o_rst_n  (o_rst_n)
    );

    reg_access_decode u_decode (
        .i_req    (i_req),
        .i_access (i_access),
        .o_rd_sel (rd_sel),
        .o_wr_sel (wr_sel)
    );

    //============================================================
    // registers
    //============================================================
    rw_reg #(.DEFAULT_VAL(MODE_DEFAULT)) u_mode (
        .i_clk      (i_clk),
        .i_rst_n    (o_rst_n),
        .i_wr_sel   (wr_sel[MODE]),
        .i_rd_sel   (rd_sel[MODE]),
        .i_wdata    (i_req.wdata),
        .o_reg_data (o_reg_mode),
        .o_rdata    (rdata_vec[MODE])
    );

    rw_reg #(.DEFAULT_VAL(COM_CONFIG1_DEFAULT)) u_com_config1 (
        .i_clk      (i_clk),
        .i_rst_n    (o_rst_n),
        .i_wr_sel   (wr_sel[COM_CONFIG1]),
        .i_rd_sel   (rd_sel[COM_CONFIG1]),
        .i_wdata    (i_req.wdata),
        .o_reg_data (o_reg_com_config1),
        .o_rdata    (rdata_vec[COM_CONFIG1])
    );

    rw_reg #(.DEFAULT_VAL(COM_CONFIG2_DEFAULT)) u_com_config2 (
        .i_clk      (i_clk),
        .i_rst_n    (o_rst_n),
        .i_wr_sel   (wr_sel[COM_CONFIG2]),
        .i_rd_sel   (rd_sel[COM_CONFIG2]),
        .i_wdata    (i_req.wdata),
        .o_reg_data (o_reg_com_config2),
        .o_rdata    (rdata_vec[COM_CONFIG2])
    );

    rwc_reg u_status1 (
        .i_clk      (i_clk),
        .i_rst_n    (o_rst_n),
        .i_wr_sel   (wr_sel[STATUS1]),
        .i_rd_sel   (rd_sel[STATUS1]),
        .i_wdata    (i_req.wdata),
        .i_event    (i_int_status1),
        .o_reg_data (o_reg_status1),
        .o_rdata    (rdata_vec[STATUS1])
    );

    rw_reg #(.DEFAULT_VAL(MASK_DEFAULT)) u_mask1 (
        .i_clk      (i_clk),
        .i_rst_n    (o_rst_n),
        .i_wr_sel   (wr_sel[MASK1]),
        .i_rd_sel   (rd_sel[MASK1]),
        .i_wdata    (i_req.wdata),
        .o_reg_data (o_reg_mask1),
        .o_rdata    (rdata_vec[MASK1])
    );

    rwc_reg u_status2 (
        .i_clk      (i_clk),
        .i_rst_n    (o_rst_n),
        .i_wr_sel   (wr_sel[STATUS2]),
        .i_rd_sel   (rd_sel[STATUS2]),
        .i_wdata    (i_req.wdata),
        .i_event    (i_int_status2),
        .o_reg_data (o_reg_status2),
        .o_rdata    (rdata_vec[STATUS2])
    );

    rw_reg #(.DEFAULT_VAL(MASK_DEFAULT)) u_mask2 (
        .i_clk      (i_clk),
        .i_rst_n    (o_rst_n),
        .i_wr_sel   (wr_sel[MASK2]),
        .i_rd_sel   (rd_sel[MASK2]),
        .i_wdata    (i_req.wdata),
        .o_reg_data (o_reg_mask2),
        .o_rdata    (rdata_vec[MASK2])
    );

    //============================================================
    // response
    //============================================================
    reg_read_return u_read_return (
        .i_clk       (i_clk),
        .i_rst_n     (i_arst_n),
        .i_req       (i_req),
        .i_id_sel    (rd_sel[DEVICE_ID]),
        .i_rdata_vec (rdata_vec),
        .o_rsp       (o_rsp)
    );

endmodule

`default_nettype wire

/* bench/tb_ref_model.svh */
// Expected register contents and reference functions for the bank.
// Included inside the testbench module, after the package imports.
// Permissions follow the access rules of the register map, not the RTL table.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam reg_addr_t MAP_ADDR [NUM_REGS] = '{
    ADDR_DEVICE_ID, ADDR_MODE, ADDR_COM_CONFIG1, ADDR_COM_CONFIG2,
    ADDR_STATUS1, ADDR_MASK1, ADDR_STATUS2, ADDR_MASK2
};

reg_data_t model_regs [NUM_REGS];

function automatic void model_reset();
    model_regs[DEVICE_ID]   = '0;
    model_regs[MODE]        = MODE_DEFAULT;
    model_regs[COM_CONFIG1] = COM_CONFIG1_DEFAULT;
    model_regs[COM_CONFIG2] = COM_CONFIG2_DEFAULT;
    model_regs[STATUS1]     = STATUS_DEFAULT;
    model_regs[MASK1]       = MASK_DEFAULT;
    model_regs[STATUS2]     = STATUS_DEFAULT;
    model_regs[MASK2]       = MASK_DEFAULT;
endfunction

function automatic bit find_reg(input reg_addr_t addr, output reg_id_e id);
    find_reg = 1'b0;
    id       = DEVICE_ID;
    for (int i = 0; i < NUM_REGS; i++) begin
        if (MAP_ADDR[i] == addr) begin
            find_reg = 1'b1;
            id       = reg_id_e'(i);
        end
    end
endfunction

// nothing is readable in cfg state
function automatic bit read_allowed(input access_state_t acc);
    return acc.test | acc.spi_ctrl;
endfunction

function automatic bit write_allowed(input reg_id_e id, input access_state_t acc);
    case (id)
        MODE:                                   return acc.test | acc.cfg | acc.spi_ctrl;
        COM_CONFIG1, COM_CONFIG2, MASK1, MASK2: return acc.test | acc.cfg;
        STATUS1, STATUS2:                       return acc.cfg | acc.spi_ctrl;
        default:                                return 1'b0;
    endcase
endfunction

function automatic reg_data_t exp_read(input reg_addr_t addr, input access_state_t acc);
    reg_id_e id;
    bit      hit;
    hit = find_reg(addr, id);
    if (!hit || !read_allowed(acc)) begin
        return '0;
    end
    return (id == DEVICE_ID) ? 8'h5A : model_regs[id];
endfunction

// status registers clear where the written bit is 1
function automatic void exp_write(input reg_addr_t addr, input reg_data_t wdata,
                                  input access_state_t acc);
    reg_id_e id;
    bit      hit;
    hit = find_reg(addr, id);
    if (hit && write_allowed(id, acc)) begin
        if (id == STATUS1 || id == STATUS2) begin
            model_regs[id] = model_regs[id] & ~wdata;
        end else begin
            model_regs[id] = wdata;
        end
    end
endfunction

`endif

/* bench/tb_com_reg_bank.sv */
// Testbench for the control register bank.
// Every cycle after reset queues one expected response, checked on the falling edge.
// The port stays idle while a soft reset is in progress.
`timescale 1ns/1ps
`default_nettype none

module tb_com_reg_bank;

    import reg_access_pkg::*;
    import reg_map_pkg::*;

    `include "tb_ref_model.svh"

    localparam int NUM_RANDOM     = 400;
    // directed tests and reset stay well under 100 cycles
    localparam int TIMEOUT_CYCLES = 4 * (NUM_RANDOM + 100);
    localparam access_state_t ACC_TEST = 3'b100;
    localparam access_state_t ACC_CFG  = 3'b010;
    localparam access_state_t ACC_SPI  = 3'b001;

    typedef struct packed {
        int        due;
        logic      wack;
        logic      rack;
        reg_data_t rdata;
        logic      rst_n;
        reg_data_t mode;
        reg_data_t config1;
        reg_data_t config2;
        reg_data_t status1;
        reg_data_t mask1;
        reg_data_t status2;
        reg_data_t mask2;
    } expect_t;

    logic          clk;
    logic          i_arst_n;
    reg_req_t      i_req;
    access_state_t i_access;
    reg_data_t     i_int_status1;
    reg_data_t     i_int_status2;
    reg_rsp_t      o_rsp;
    mode_reg_t     o_reg_mode;
    reg_data_t     o_reg_com_config1;
    reg_data_t     o_reg_com_config2;
    reg_data_t     o_reg_status1;
    reg_data_t     o_reg_mask1;
    reg_data_t     o_reg_status2;
    reg_data_t     o_reg_mask2;
    logic          o_rst_n;

    expect_t     exp_q [$];
    int          ncount    = 0;
    int          cycles    = 0;
    int          hold_left = 0;
    int unsigned rng_state = 32'd63112;

    com_reg_bank dut (
        .i_clk             (clk),
        .i_arst_n          (i_arst_n),
        .i_req             (i_req),
        .i_access          (i_access),
        .i_int_status1     (i_int_status1),
        .i_int_status2     (i_int_status2),
        .o_rsp             (o_rsp),
        .o_reg_mode        (o_reg_mode),
        .o_reg_com_config1 (o_reg_com_config1),
        .o_reg_com_config2 (o_reg_com_config2),
        .o_reg_status1     (o_reg_status1),
        .o_reg_mask1       (o_reg_mask1),
        .o_reg_status2     (o_reg_status2),
        .o_reg_mask2       (o_reg_mask2),
        .o_rst_n           (o_rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s expected 0x%02h got 0x%02h",
                               $time, name, exp, got));
        end
    endtask

    task automatic check_ack(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s expected %0b got %0b",
                               $time, name, exp, got));
        end
    endtask

    //============================================================
    // one request per cycle and the model updated in issue order
    //============================================================
    task automatic step(input reg_req_t req, input access_state_t acc,
                        input reg_data_t ev1, input reg_data_t ev2);
        expect_t e;
        @(posedge clk);
        i_req         <= req;
        i_access      <= acc;
        i_int_status1 <= ev1;
        i_int_status2 <= ev2;
        e.due   = ncount + 2;
        e.rack  = req.ren;
        e.wack  = req.wen;
        e.rdata = req.ren ? exp_read(req.addr, acc) : '0;
        if (hold_left > 0) begin
            hold_left = hold_left - 1;
            model_reset();
            e.rst_n = 1'b0;
        end else begin
            e.rst_n = 1'b1;
            if (req.wen) begin
                exp_write(req.addr, req.wdata, acc);
            end
            // events land after the clear so a same-edge set wins
            model_regs[STATUS1] = model_regs[STATUS1] | ev1;
            model_regs[STATUS2] = model_regs[STATUS2] | ev2;
            if (model_regs[MODE][0]) begin
                hold_left = SRST_HOLD_CYCLES;
            end
        end
        e.mode    = model_regs[MODE];
        e.config1 = model_regs[COM_CONFIG1];
        e.config2 = model_regs[COM_CONFIG2];
        e.status1 = model_regs[STATUS1];
        e.mask1   = model_regs[MASK1];
        e.status2 = model_regs[STATUS2];
        e.mask2   = model_regs[MASK2];
        exp_q.push_back(e);
    endtask

    task automatic read_reg(input reg_addr_t addr, input access_state_t acc);
        step('{ren: 1'b1, wen: 1'b0, addr: addr, wdata: '0}, acc, '0, '0);
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data,
                             input access_state_t acc);
        step('{ren: 1'b0, wen: 1'b1, addr: addr, wdata: data}, acc, '0, '0);
    endtask

    task automatic idle(input int n);
        repeat (n) step('0, '0, '0, '0);
    endtask

    //============================================================
    // compare on the falling edge where outputs are stable
    //============================================================
    always @(negedge clk) begin : compare_responses
        expect_t e;
        ncount = ncount + 1;
        if (exp_q.size() > 0 && exp_q[0].due == ncount) begin
            e = exp_q.pop_front();
            check_ack("o_rsp.rack", o_rsp.rack, e.rack);
            check_ack("o_rsp.wack", o_rsp.wack, e.wack);
            if (e.rack) begin
                check_data("o_rsp.rdata", o_rsp.rdata, e.rdata);
            end
            check_ack("o_rst_n", o_rst_n, e.rst_n);
            check_data("o_reg_mode", o_reg_mode, e.mode);
            check_data("o_reg_com_config1", o_reg_com_config1, e.config1);
            check_data("o_reg_com_config2", o_reg_com_config2, e.config2);
            check_data("o_reg_status1", o_reg_status1, e.status1);
            check_data("o_reg_mask1", o_reg_mask1, e.mask1);
            check_data("o_reg_status2", o_reg_status2, e.status2);
            check_data("o_reg_mask2", o_reg_mask2, e.mask2);
        end else begin
            check_ack("o_rsp.rack", o_rsp.rack, 1'b0);
            check_ack("o_rsp.wack", o_rsp.wack, 1'b0);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin : main
        int unsigned r;
        reg_addr_t   addr;
        reg_data_t   data;
        i_arst_n      = 1'b0;
        i_req         = '0;
        i_access      = '0;
        i_int_status1 = '0;
        i_int_status2 = '0;
        model_reset();
        repeat (10) @(posedge clk);
        i_arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_ack("o_rst_n", o_rst_n, 1'b1);

        // defaults and the identifier
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(MAP_ADDR[i], ACC_TEST);
        end

        // write then read on the next cycle
        for (int i = 1; i < 5; i++) begin
            data = reg_data_t'(xorshift32()) & 8'hFE;
            write_reg(MAP_ADDR[i], data, ACC_TEST);
            read_reg(MAP_ADDR[i], ACC_SPI);
        end
        write_reg(ADDR_MASK2, 8'hC3, ACC_CFG);
        write_reg(ADDR_COM_CONFIG1, 8'h5E, ACC_TEST);
        read_reg(ADDR_MASK2, ACC_TEST);
        read_reg(ADDR_COM_CONFIG1, ACC_SPI);

        // status set, clear, and set against clear on one edge
        step('0, '0, 8'hA5, 8'h3C);
        read_reg(ADDR_STATUS1, ACC_SPI);
        write_reg(ADDR_STATUS1, 8'h0F, ACC_CFG);
        read_reg(ADDR_STATUS1, ACC_TEST);
        step('{ren: 1'b0, wen: 1'b1, addr: ADDR_STATUS2, wdata: 8'hFF}, ACC_SPI, '0, 8'h81);
        read_reg(ADDR_STATUS2, ACC_TEST);

        // random traffic with srst kept clear
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r    = xorshift32();
            addr = (r[1:0] == 2'b00) ? reg_addr_t'(r[14:8]) : MAP_ADDR[r[4:2]];
            data = reg_data_t'(xorshift32());
            if (addr == ADDR_MODE) begin
                data[0] = 1'b0;
            end
            step('{ren: r[16], wen: ~r[16] & r[17], addr: addr, wdata: data},
                 access_state_t'(r[7:5]),
                 reg_data_t'(xorshift32() & xorshift32() & xorshift32()),
                 reg_data_t'(xorshift32() & xorshift32() & xorshift32()));
        end

        // soft reset then every register back at its default
        write_reg(ADDR_COM_CONFIG1, 8'h77, ACC_TEST);
        write_reg(ADDR_MASK2, 8'h11, ACC_CFG);
        write_reg(ADDR_MODE, 8'h35, ACC_SPI);
        idle(4);
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(MAP_ADDR[i], ACC_TEST);
        end

        idle(2);
        repeat (3) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_run("responses still expected at end of run");
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+bench
source/reg_access_pkg.sv
source/reg_map_pkg.sv
source/rstn_merge.sv
source/reg_access_decode.sv
source/rw_reg.sv
source/rwc_reg.sv
source/reg_read_return.sv
source/com_reg_bank.sv
bench/tb_com_reg_bank.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it, and passes only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_com_reg_bank -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
